//--- filelist.f
+incdir+test
src/rs_pkg.sv
src/dispatch_lane_select.sv
src/operand_capture.sv
src/reservation_station.sv
src/int_alu.sv
src/issue_cluster_top.sv
test/issue_cluster_tb.sv

//--- src/dispatch_lane_select.sv
/*
 * Dispatch input side of the cluster.
 * Picks the one lane that carries an ALU instruction for this station.
 */

module dispatch_lane_select #(
	parameter int NLANE = 2,
	parameter logic [NLANE-1:0] DISPATCH_MAP = '1
) (
	input  logic [NLANE-1:0]                            lane_valid_i,
	input  rs_pkg::funcunit_e [NLANE-1:0]               lane_unit_i,
	input  rs_pkg::opcode_e [NLANE-1:0]                 lane_op_i,
	input  logic [NLANE-1:0][rs_pkg::PREG_W-1:0]        lane_dst_i,
	input  logic [NLANE-1:0][rs_pkg::ROB_W-1:0]         lane_rob_i,
	input  logic [NLANE-1:0][1:0][rs_pkg::PREG_W-1:0]   lane_src_tag_i,
	input  logic [NLANE-1:0][1:0]                       lane_src_present_i,
	input  logic [NLANE-1:0][1:0][rs_pkg::DATA_W-1:0]   lane_src_value_i,
	output logic                                        sel_valid_o,
	output rs_pkg::opcode_e                             sel_op_o,
	output logic [rs_pkg::PREG_W-1:0]                   sel_dst_o,
	output logic [rs_pkg::ROB_W-1:0]                    sel_rob_o,
	output logic [1:0][rs_pkg::PREG_W-1:0]              sel_src_tag_o,
	output logic [1:0]                                  sel_src_present_o,
	output logic [1:0][rs_pkg::DATA_W-1:0]              sel_src_value_o
);

	import rs_pkg::*;

	// Scan every lane, later matches override earlier ones
	// so the highest-numbered matching lane wins
	always_comb begin
		// Nothing selected gives all-zero fields
		sel_valid_o       = 1'b0;
		sel_op_o          = opcode_e'('0);
		sel_dst_o         = '0;
		sel_rob_o         = '0;
		sel_src_tag_o     = '0;
		sel_src_present_o = '0;
		sel_src_value_o   = '0;
		for (int i = 0; i < NLANE; i++) begin
			// Only lanes wired to this unit type are looked at
			if (DISPATCH_MAP[i] && lane_valid_i[i] && lane_unit_i[i] == FU_ALU) begin
				sel_valid_o       = 1'b1;
				sel_op_o          = lane_op_i[i];
				sel_dst_o         = lane_dst_i[i];
				sel_rob_o         = lane_rob_i[i];
				sel_src_tag_o     = lane_src_tag_i[i];
				sel_src_present_o = lane_src_present_i[i];
				sel_src_value_o   = lane_src_value_i[i];
			end
		end
	end

endmodule

//--- src/int_alu.sv
/*
 * One-stage integer ALU behind the reservation station.
 * Executes the issued entry and drives the result bus on the next cycle.
 */

module int_alu (
	input  logic                      clk,
	input  logic                      rst,
	// Issue port from the station
	input  logic                      issue_valid_i,
	input  rs_pkg::opcode_e           op_i,
	input  logic [rs_pkg::DATA_W-1:0] a_i,
	input  logic [rs_pkg::DATA_W-1:0] b_i,
	input  logic [rs_pkg::PREG_W-1:0] dst_i,
	// Result bus, also fed back for operand capture
	output logic                      result_valid_o,
	output logic [rs_pkg::PREG_W-1:0] result_tag_o,
	output logic [rs_pkg::DATA_W-1:0] result_value_o
);

	import rs_pkg::*;

	// Shift amount comes from the low bits of b
	localparam int SHAMT_W = $clog2(DATA_W);

	logic [SHAMT_W-1:0] shamt;
	logic [DATA_W-1:0]  alu_value;

	assign shamt = b_i[SHAMT_W-1:0];

	// ========================================================================
	// Execute
	// ========================================================================

	always_comb begin
		case (op_i)
			OP_ADD:  alu_value = a_i + b_i;
			// a minus b
			OP_SUB:  alu_value = a_i - b_i;
			OP_AND:  alu_value = a_i & b_i;
			OP_OR:   alu_value = a_i | b_i;
			OP_XOR:  alu_value = a_i ^ b_i;
			// Logical shifts, zero fill
			OP_SLL:  alu_value = a_i << shamt;
			OP_SRL:  alu_value = a_i >> shamt;
			// NOP arrives with valid low
			default: alu_value = '0;
		endcase
	end

	// ========================================================================
	// Result register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= issue_valid_i;
		end
	end

	// Tag and value only matter with valid high
	always_ff @(posedge clk) begin
		result_tag_o   <= dst_i;
		result_value_o <= alu_value;
	end

endmodule

//--- src/issue_cluster_top.sv
/*
 * Integer issue cluster: lane selector, reservation station and ALU.
 * The ALU result bus leaves the cluster and also wakes up waiting operands.
 */

module issue_cluster_top #(
	parameter int NRSE = 4,
	parameter int NLANE = 2,
	parameter logic [NLANE-1:0] DISPATCH_MAP = '1
) (
	input  logic                                      clk,
	input  logic                                      rst,
	// Dispatch lanes
	input  logic [NLANE-1:0]                          lane_valid_i,
	input  rs_pkg::funcunit_e [NLANE-1:0]             lane_unit_i,
	input  rs_pkg::opcode_e [NLANE-1:0]               lane_op_i,
	input  logic [NLANE-1:0][rs_pkg::PREG_W-1:0]      lane_dst_i,
	input  logic [NLANE-1:0][rs_pkg::ROB_W-1:0]       lane_rob_i,
	input  logic [NLANE-1:0][1:0][rs_pkg::PREG_W-1:0] lane_src_tag_i,
	input  logic [NLANE-1:0][1:0]                     lane_src_present_i,
	input  logic [NLANE-1:0][1:0][rs_pkg::DATA_W-1:0] lane_src_value_i,
	// Flow control and cancel
	input  logic                                      available_i,
	input  logic                                      stall_i,
	input  logic [rs_pkg::STOMP_W-1:0]                stomp_i,
	// Bypass bus from other units
	input  logic                                      byp_valid_i,
	input  logic [rs_pkg::PREG_W-1:0]                 byp_tag_i,
	input  logic [rs_pkg::DATA_W-1:0]                 byp_value_i,
	// Status and ALU result bus
	output logic                                      busy_o,
	output logic                                      result_valid_o,
	output logic [rs_pkg::PREG_W-1:0]                 result_tag_o,
	output logic [rs_pkg::DATA_W-1:0]                 result_value_o
);

	import rs_pkg::*;

	// Selected dispatch
	logic                   sel_valid;
	opcode_e                sel_op;
	logic [PREG_W-1:0]      sel_dst;
	logic [ROB_W-1:0]       sel_rob;
	logic [1:0][PREG_W-1:0] sel_src_tag;
	logic [1:0]             sel_src_present;
	logic [1:0][DATA_W-1:0] sel_src_value;

	// Station to ALU
	logic                   issue_valid;
	opcode_e                issue_op;
	logic [DATA_W-1:0]      issue_a;
	logic [DATA_W-1:0]      issue_b;
	logic [PREG_W-1:0]      issue_dst;

	dispatch_lane_select #(
		.NLANE        (NLANE),
		.DISPATCH_MAP (DISPATCH_MAP)
	) u_lane_select (
		.lane_valid_i       (lane_valid_i),
		.lane_unit_i        (lane_unit_i),
		.lane_op_i          (lane_op_i),
		.lane_dst_i         (lane_dst_i),
		.lane_rob_i         (lane_rob_i),
		.lane_src_tag_i     (lane_src_tag_i),
		.lane_src_present_i (lane_src_present_i),
		.lane_src_value_i   (lane_src_value_i),
		.sel_valid_o        (sel_valid),
		.sel_op_o           (sel_op),
		.sel_dst_o          (sel_dst),
		.sel_rob_o          (sel_rob),
		.sel_src_tag_o      (sel_src_tag),
		.sel_src_present_o  (sel_src_present),
		.sel_src_value_o    (sel_src_value)
	);

	// ALU result bus loops back for wakeup
	reservation_station #(
		.NRSE (NRSE)
	) u_station (
		.clk               (clk),
		.rst               (rst),
		.available_i       (available_i),
		.stall_i           (stall_i),
		.stomp_i           (stomp_i),
		.sel_valid_i       (sel_valid),
		.sel_op_i          (sel_op),
		.sel_dst_i         (sel_dst),
		.sel_rob_i         (sel_rob),
		.sel_src_tag_i     (sel_src_tag),
		.sel_src_present_i (sel_src_present),
		.sel_src_value_i   (sel_src_value),
		.res_valid_i       (result_valid_o),
		.res_tag_i         (result_tag_o),
		.res_value_i       (result_value_o),
		.byp_valid_i       (byp_valid_i),
		.byp_tag_i         (byp_tag_i),
		.byp_value_i       (byp_value_i),
		.busy_o            (busy_o),
		.issue_valid_o     (issue_valid),
		.issue_op_o        (issue_op),
		.issue_a_o         (issue_a),
		.issue_b_o         (issue_b),
		.issue_dst_o       (issue_dst),
		// Completion index goes to the reorder buffer outside this cluster
		.issue_rob_o       ()
	);

	int_alu u_alu (
		.clk            (clk),
		.rst            (rst),
		.issue_valid_i  (issue_valid),
		.op_i           (issue_op),
		.a_i            (issue_a),
		.b_i            (issue_b),
		.dst_i          (issue_dst),
		.result_valid_o (result_valid_o),
		.result_tag_o   (result_tag_o),
		.result_value_o (result_value_o)
	);

endmodule

//--- src/operand_capture.sv
/*
 * Wakeup logic for one source operand.
 * Compares a waiting tag against the ALU result bus and the bypass bus
 * and returns the operand with the bus value filled in on a hit.
 */

module operand_capture (
	// Operand as currently held
	input  logic [rs_pkg::PREG_W-1:0] tag_i,
	input  logic                      present_i,
	input  logic [rs_pkg::DATA_W-1:0] value_i,
	// ALU result bus
	input  logic                      res_valid_i,
	input  logic [rs_pkg::PREG_W-1:0] res_tag_i,
	input  logic [rs_pkg::DATA_W-1:0] res_value_i,
	// External bypass bus
	input  logic                      byp_valid_i,
	input  logic [rs_pkg::PREG_W-1:0] byp_tag_i,
	input  logic [rs_pkg::DATA_W-1:0] byp_value_i,
	// Operand after this cycle's capture
	output logic                      present_o,
	output logic [rs_pkg::DATA_W-1:0] value_o
);

	logic res_hit;
	logic byp_hit;

	// Tag compare per bus
	// a present operand never looks at the buses
	assign res_hit = !present_i && res_valid_i && (res_tag_i == tag_i);
	assign byp_hit = !present_i && byp_valid_i && (byp_tag_i == tag_i);

	// Present once either bus delivers the tag
	assign present_o = present_i || res_hit || byp_hit;

	// Value select
	always_comb begin
		if (res_hit) begin
			// Own ALU result takes priority
			value_o = res_value_i;
		end else if (byp_hit) begin
			value_o = byp_value_i;
		end else begin
			// Keep what is held, missing operands carry a don't-care value
			value_o = value_i;
		end
	end

endmodule

//--- src/reservation_station.sv
/*
 * Reservation station for the integer ALU.
 * Holds NRSE entries, wakes up operands from the result buses and issues
 * the highest-numbered ready entry each cycle unless stalled.
 */

module reservation_station #(
	parameter int NRSE = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	// Dispatch handshake
	input  logic                       available_i,
	input  logic                       stall_i,
	input  logic [rs_pkg::STOMP_W-1:0] stomp_i,
	input  logic                       sel_valid_i,
	input  rs_pkg::opcode_e            sel_op_i,
	input  logic [rs_pkg::PREG_W-1:0]  sel_dst_i,
	input  logic [rs_pkg::ROB_W-1:0]   sel_rob_i,
	input  logic [1:0][rs_pkg::PREG_W-1:0] sel_src_tag_i,
	input  logic [1:0]                 sel_src_present_i,
	input  logic [1:0][rs_pkg::DATA_W-1:0] sel_src_value_i,
	// Result buses
	input  logic                       res_valid_i,
	input  logic [rs_pkg::PREG_W-1:0]  res_tag_i,
	input  logic [rs_pkg::DATA_W-1:0]  res_value_i,
	input  logic                       byp_valid_i,
	input  logic [rs_pkg::PREG_W-1:0]  byp_tag_i,
	input  logic [rs_pkg::DATA_W-1:0]  byp_value_i,
	// Station status and issue port
	output logic                       busy_o,
	output logic                       issue_valid_o,
	output rs_pkg::opcode_e            issue_op_o,
	output logic [rs_pkg::DATA_W-1:0]  issue_a_o,
	output logic [rs_pkg::DATA_W-1:0]  issue_b_o,
	output logic [rs_pkg::PREG_W-1:0]  issue_dst_o,
	output logic [rs_pkg::ROB_W-1:0]   issue_rob_o
);

	import rs_pkg::*;

	localparam int IDX_W = (NRSE > 1) ? $clog2(NRSE) : 1;

	// ========================================================================
	// Entry storage
	// ========================================================================

	logic [NRSE-1:0]             ent_busy;
	logic [NRSE-1:0]             ent_ready;
	opcode_e                     ent_op      [NRSE];
	logic [PREG_W-1:0]           ent_dst     [NRSE];
	logic [ROB_W-1:0]            ent_rob     [NRSE];
	logic [1:0][PREG_W-1:0]      ent_tag     [NRSE];
	logic [1:0]                  ent_present [NRSE];
	logic [1:0][DATA_W-1:0]      ent_value   [NRSE];

	// Capture results for held entries and for the incoming instruction
	logic [1:0]                  cap_present [NRSE];
	logic [1:0][DATA_W-1:0]      cap_value   [NRSE];
	logic [1:0]                  disp_present;
	logic [1:0][DATA_W-1:0]      disp_value;

	logic                        stall_q;
	logic                        accept;
	logic                        alloc_found;
	logic [IDX_W-1:0]            alloc_idx;
	logic                        iss_found;
	logic [IDX_W-1:0]            iss_idx;
	logic                        can_issue;
	opcode_e                     iss_op;
	opcode_e                     disp_op;

	// ========================================================================
	// Operand wakeup
	// ========================================================================

	for (genvar s = 0; s < 2; s++) begin : g_disp_src
		// Value arriving on a bus in the dispatch cycle is taken directly
		operand_capture u_disp_cap (
			.tag_i       (sel_src_tag_i[s]),
			.present_i   (sel_src_present_i[s]),
			.value_i     (sel_src_value_i[s]),
			.res_valid_i (res_valid_i),
			.res_tag_i   (res_tag_i),
			.res_value_i (res_value_i),
			.byp_valid_i (byp_valid_i),
			.byp_tag_i   (byp_tag_i),
			.byp_value_i (byp_value_i),
			.present_o   (disp_present[s]),
			.value_o     (disp_value[s])
		);
	end

	for (genvar e = 0; e < NRSE; e++) begin : g_entry
		for (genvar s = 0; s < 2; s++) begin : g_src
			operand_capture u_cap (
				.tag_i       (ent_tag[e][s]),
				.present_i   (ent_present[e][s]),
				.value_i     (ent_value[e][s]),
				.res_valid_i (res_valid_i),
				.res_tag_i   (res_tag_i),
				.res_value_i (res_value_i),
				.byp_valid_i (byp_valid_i),
				.byp_tag_i   (byp_tag_i),
				.byp_value_i (byp_value_i),
				.present_o   (cap_present[e][s]),
				.value_o     (cap_value[e][s])
			);
		end
	end

	// ========================================================================
	// Allocation and issue select
	// ========================================================================

	// Full only when every entry is occupied
	assign busy_o = &ent_busy;
	assign accept = available_i && sel_valid_i && !busy_o;

	// Highest-numbered idle and ready entries win
	always_comb begin
		alloc_found = 1'b0;
		alloc_idx   = '0;
		iss_found   = 1'b0;
		iss_idx     = '0;
		for (int i = 0; i < NRSE; i++) begin
			if (!ent_busy[i]) begin
				alloc_found = 1'b1;
				alloc_idx   = IDX_W'(i);
			end
			if (ent_busy[i] && ent_ready[i]) begin
				iss_found = 1'b1;
				iss_idx   = IDX_W'(i);
			end
		end
	end

	// Stall now or in the previous cycle blocks issue
	assign can_issue = iss_found && !stall_i && !stall_q;

	// Stomp checked again at issue time
	assign iss_op  = stomp_to_nop(ent_op[iss_idx], stomp_i, ent_rob[iss_idx]);
	assign disp_op = stomp_to_nop(sel_op_i, stomp_i, sel_rob_i);

	// ========================================================================
	// Entry update
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ent_busy      <= '0;
			ent_ready     <= '0;
			issue_valid_o <= 1'b0;
			stall_q       <= 1'b0;
		end else begin
			stall_q       <= stall_i;
			issue_valid_o <= 1'b0;

			// Capture and readiness, ready lags the stored operands by one edge
			for (int i = 0; i < NRSE; i++) begin
				if (ent_busy[i]) begin
					ent_present[i] <= cap_present[i];
					ent_value[i]   <= cap_value[i];
				end
				ent_ready[i] <= ent_busy[i] && ((&ent_present[i]) || !writes_result(ent_op[i]));
			end

			// Issue frees the entry, stomped work leaves as an invalid NOP
			if (can_issue) begin
				issue_valid_o       <= writes_result(iss_op);
				issue_op_o          <= iss_op;
				issue_a_o           <= ent_value[iss_idx][0];
				issue_b_o           <= ent_value[iss_idx][1];
				issue_dst_o         <= ent_dst[iss_idx];
				issue_rob_o         <= ent_rob[iss_idx];
				ent_busy[iss_idx]   <= 1'b0;
				ent_ready[iss_idx]  <= 1'b0;
			end

			// Dispatch write, a NOP needs no operands
			if (accept && alloc_found) begin
				ent_busy[alloc_idx]    <= 1'b1;
				ent_ready[alloc_idx]   <= (&disp_present) || !writes_result(disp_op);
				ent_op[alloc_idx]      <= disp_op;
				ent_dst[alloc_idx]     <= sel_dst_i;
				ent_rob[alloc_idx]     <= sel_rob_i;
				ent_tag[alloc_idx]     <= sel_src_tag_i;
				ent_present[alloc_idx] <= disp_present;
				ent_value[alloc_idx]   <= disp_value;
			end
		end
	end

endmodule

//--- src/rs_pkg.sv
/*
 * Shared widths, opcode and unit encodings for the integer issue cluster.
 * Imported by the lane selector, the station, the ALU and the top level.
 */

package rs_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// Operand and result width
	localparam int DATA_W  = 32;
	// Physical register tag width
	localparam int PREG_W  = 6;
	// Reorder-buffer index width
	localparam int ROB_W   = 4;
	// One stomp bit per reorder-buffer index
	localparam int STOMP_W = 1 << ROB_W;

	// ========================================================================
	// Encodings
	// ========================================================================

	// ALU operations, NOP marks cancelled work
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SLL = 4'd5,
		OP_SRL = 4'd6,
		OP_NOP = 4'd15
	} opcode_e;

	// Functional unit classes seen on the dispatch lanes
	typedef enum logic [1:0] {
		FU_ALU = 2'd0,
		FU_FPU = 2'd1,
		FU_MEM = 2'd2
	} funcunit_e;

	// Wrong-path work turns into a NOP
	function automatic opcode_e stomp_to_nop(opcode_e op, logic [STOMP_W-1:0] stomp,
		logic [ROB_W-1:0] rob);
		return stomp[rob] ? OP_NOP : op;
	endfunction

	// A NOP never writes the result bus
	function automatic logic writes_result(opcode_e op);
		return op != OP_NOP;
	endfunction

endpackage

//--- test/issue_cluster_model.svh
/*
 * Reference model for the issue cluster testbench, included in its module body.
 * Keeps the expected value per destination tag and retires results as they leave.
 */

`ifndef ISSUE_CLUSTER_MODEL_SVH
`define ISSUE_CLUSTER_MODEL_SVH

// Expected results indexed by destination tag
logic [DATA_W-1:0] exp_value   [1 << PREG_W];
logic              exp_pending [1 << PREG_W];
logic              seen_tag    [1 << PREG_W];
int                pending_count = 0;
int                checked_count = 0;

// Integer ALU rule, shift amount is the low five bits of b
function automatic logic [DATA_W-1:0] reference_alu(input opcode_e op,
	input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
	case (op)
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_OR:   return a | b;
		OP_XOR:  return a ^ b;
		OP_SLL:  return a << b[4:0];
		OP_SRL:  return a >> b[4:0];
		default: return '0;
	endcase
endfunction

task automatic clear_model();
	for (int i = 0; i < (1 << PREG_W); i++) begin
		exp_pending[i] = 1'b0;
		seen_tag[i]    = 1'b0;
		exp_value[i]   = '0;
	end
endtask

task automatic expect_result(input logic [PREG_W-1:0] tag, input logic [DATA_W-1:0] value);
	exp_value[tag]   = value;
	exp_pending[tag] = 1'b1;
	pending_count++;
endtask

// True when this tag is awaited with exactly this value
function automatic logic result_matches(input logic [PREG_W-1:0] tag,
	input logic [DATA_W-1:0] value);
	return exp_pending[tag] && (exp_value[tag] == value);
endfunction

// A second result on the same tag finds nothing pending
task automatic retire_result(input logic [PREG_W-1:0] tag);
	seen_tag[tag] = 1'b1;
	if (exp_pending[tag]) begin
		exp_pending[tag] = 1'b0;
		pending_count--;
		checked_count++;
	end
endtask

`endif

//--- test/issue_cluster_tb.sv
/*
 * Testbench for the integer issue cluster.
 * Runs six directed tests over dispatch, bypass, stomp, stall and lane
 * filtering and checks every ALU result by tag against a reference model.
 */

module issue_cluster_tb;

	import rs_pkg::*;

	localparam int NRSE         = 4;
	localparam int NLANE        = 2;
	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	// Instructions sent per test
	localparam int LEN_OPCODE   = 7;
	localparam int LEN_BYPASS   = 2;
	localparam int LEN_CHAIN    = 2;
	localparam int LEN_STOMP    = 4;
	localparam int LEN_LANE     = 4;
	localparam int TOTAL_LEN    = LEN_OPCODE + LEN_BYPASS + LEN_CHAIN + LEN_STOMP + NRSE + LEN_LANE;
	localparam int DRAIN_LIMIT  = 40;
	localparam int IDLE_CYCLES  = 6;

	logic                              clk = 1'b0;
	logic                              rst;
	logic [NLANE-1:0]                  lane_valid;
	funcunit_e [NLANE-1:0]             lane_unit;
	opcode_e [NLANE-1:0]               lane_op;
	logic [NLANE-1:0][PREG_W-1:0]      lane_dst;
	logic [NLANE-1:0][ROB_W-1:0]       lane_rob;
	logic [NLANE-1:0][1:0][PREG_W-1:0] lane_src_tag;
	logic [NLANE-1:0][1:0]             lane_src_present;
	logic [NLANE-1:0][1:0][DATA_W-1:0] lane_src_value;
	logic                              available;
	logic                              stall;
	logic [STOMP_W-1:0]                stomp;
	logic                              byp_valid;
	logic [PREG_W-1:0]                 byp_tag;
	logic [DATA_W-1:0]                 byp_value;
	logic                              busy;
	logic                              result_valid;
	logic [PREG_W-1:0]                 result_tag;
	logic [DATA_W-1:0]                 result_value;

	int                seed        = 29382;
	int                error_count = 0;
	int                test_count  = 0;
	int                test_start  = 0;
	logic [PREG_W-1:0] next_tag    = 6'd1;
	// Tags that must never show up on the result bus
	logic [PREG_W-1:0] absent_tags [$];
	opcode_e           alu_ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};

	`include "issue_cluster_model.svh"

	issue_cluster_top #(
		.NRSE         (NRSE),
		.NLANE        (NLANE),
		.DISPATCH_MAP ('1)
	) issue_cluster_top_i (
		.clk                (clk),
		.rst                (rst),
		.lane_valid_i       (lane_valid),
		.lane_unit_i        (lane_unit),
		.lane_op_i          (lane_op),
		.lane_dst_i         (lane_dst),
		.lane_rob_i         (lane_rob),
		.lane_src_tag_i     (lane_src_tag),
		.lane_src_present_i (lane_src_present),
		.lane_src_value_i   (lane_src_value),
		.available_i        (available),
		.stall_i            (stall),
		.stomp_i            (stomp),
		.byp_valid_i        (byp_valid),
		.byp_tag_i          (byp_tag),
		.byp_value_i        (byp_value),
		.busy_o             (busy),
		.result_valid_o     (result_valid),
		.result_tag_o       (result_tag),
		.result_value_o     (result_value)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ========================================================================
	// Result checking
	// ========================================================================

	// Result bus is stable at the falling edge
	result_check: assert property (@(negedge clk) disable iff (rst)
		result_valid |-> result_matches(result_tag, result_value))
	else begin
		$display("** Error at time %0t: tag %0d gave %08h, expected %08h (pending %0b)",
			$time, result_tag, result_value, exp_value[result_tag], exp_pending[result_tag]);
		error_count++;
	end

	// Retire after the check above has seen the cycle
	always @(posedge clk) begin
		if (!rst && result_valid) begin
			retire_result(result_tag);
		end
	end

	// ========================================================================
	// Stimulus helpers
	// ========================================================================

	task automatic tick();
		@(negedge clk);
	endtask

	task automatic clear_lanes();
		lane_valid = '0;
	endtask

	task automatic set_lane(input int lane, input funcunit_e unit, input opcode_e op,
		input logic [PREG_W-1:0] dst, input logic [ROB_W-1:0] rob,
		input logic [PREG_W-1:0] tag_a, input logic pres_a, input logic [DATA_W-1:0] val_a,
		input logic [PREG_W-1:0] tag_b, input logic pres_b, input logic [DATA_W-1:0] val_b);
		lane_valid[lane]          = 1'b1;
		lane_unit[lane]           = unit;
		lane_op[lane]             = op;
		lane_dst[lane]            = dst;
		lane_rob[lane]            = rob;
		lane_src_tag[lane][0]     = tag_a;
		lane_src_present[lane][0] = pres_a;
		lane_src_value[lane][0]   = val_a;
		lane_src_tag[lane][1]     = tag_b;
		lane_src_present[lane][1] = pres_b;
		lane_src_value[lane][1]   = val_b;
	endtask

	// One ALU instruction with both sources present on lane 0
	task automatic send_ready(input opcode_e op, input logic [ROB_W-1:0] rob,
		input logic expect_it, output logic [PREG_W-1:0] dst);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		a = $random(seed);
		b = $random(seed);
		dst = next_tag;
		next_tag++;
		set_lane(0, FU_ALU, op, dst, rob, '0, 1'b1, a, '0, 1'b1, b);
		if (expect_it) begin
			expect_result(dst, reference_alu(op, a, b));
		end else begin
			absent_tags.push_back(dst);
		end
		tick();
		clear_lanes();
	endtask

	task automatic drive_bypass(input logic [PREG_W-1:0] tag, input logic [DATA_W-1:0] value);
		byp_valid = 1'b1;
		byp_tag   = tag;
		byp_value = value;
		tick();
		byp_valid = 1'b0;
	endtask

	// Wait for every expected result, then idle so cancelled work drains too
	task automatic drain();
		int                cycles;
		logic [PREG_W-1:0] tag;
		cycles = 0;
		while (pending_count != 0 && cycles < DRAIN_LIMIT) begin
			tick();
			cycles++;
		end
		if (pending_count != 0) begin
			$display("Drain timed out with %0d results missing at time %0t", pending_count, $time);
			error_count++;
		end
		repeat (IDLE_CYCLES) tick();
		while (absent_tags.size() != 0) begin
			tag = absent_tags.pop_front();
			assert (!seen_tag[tag]) else begin
				$display("Cancelled tag %0d produced a result before time %0t", tag, $time);
				error_count++;
			end
		end
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			tick();
			assert (!result_valid) else begin
				$display("Result left the station too early at time %0t", $time);
				error_count++;
			end
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("%-16s %s, %0d errors", name, (error_count == test_start) ? "ok" : "failed",
			error_count - test_start);
		test_start = error_count;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	// Each opcode alone gives its result two edges after dispatch
	task automatic opcode_test();
		logic [PREG_W-1:0] dst;
		int                lat;
		foreach (alu_ops[i]) begin
			send_ready(alu_ops[i], '0, 1'b1, dst);
			lat = 0;
			while (!result_valid && lat < 8) begin
				tick();
				lat++;
			end
			assert (result_valid && result_tag == dst && lat == 2) else begin
				$display("** Error at time %0t: %s on tag %0d took %0d cycles, expected 2",
					$time, alu_ops[i].name(), dst, lat);
				error_count++;
			end
		end
		drain();
		end_test("opcodes");
	endtask

	task automatic bypass_test();
		logic [DATA_W-1:0] va;
		logic [DATA_W-1:0] vb;
		logic [DATA_W-1:0] vc;
		logic [DATA_W-1:0] vd;
		logic [PREG_W-1:0] dst;
		va = $random(seed);
		vb = $random(seed);
		vc = $random(seed);
		vd = $random(seed);
		// Both sources wait on bypass tags 40 and 41
		dst = next_tag;
		next_tag++;
		set_lane(0, FU_ALU, OP_ADD, dst, '0, 6'd40, 1'b0, '0, 6'd41, 1'b0, '0);
		expect_result(dst, reference_alu(OP_ADD, va, vb));
		tick();
		clear_lanes();
		expect_quiet(4);
		drive_bypass(6'd40, va);
		drive_bypass(6'd41, vb);
		// Source B arrives on the bypass bus in its own dispatch cycle
		dst = next_tag;
		next_tag++;
		set_lane(0, FU_ALU, OP_SUB, dst, '0, '0, 1'b1, vc, 6'd42, 1'b0, '0);
		expect_result(dst, reference_alu(OP_SUB, vc, vd));
		byp_valid = 1'b1;
		byp_tag   = 6'd42;
		byp_value = vd;
		tick();
		clear_lanes();
		byp_valid = 1'b0;
		drain();
		end_test("bypass_wakeup");
	endtask

	// Second instruction wakes up on the first one's result
	task automatic chain_test();
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] c;
		logic [PREG_W-1:0] first;
		logic [PREG_W-1:0] second;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		first = next_tag;
		next_tag++;
		second = next_tag;
		next_tag++;
		set_lane(0, FU_ALU, OP_XOR, first, '0, '0, 1'b1, a, '0, 1'b1, b);
		expect_result(first, reference_alu(OP_XOR, a, b));
		tick();
		set_lane(0, FU_ALU, OP_ADD, second, '0, first, 1'b0, '0, '0, 1'b1, c);
		expect_result(second, reference_alu(OP_ADD, reference_alu(OP_XOR, a, b), c));
		tick();
		clear_lanes();
		drain();
		end_test("dependent_chain");
	endtask

	task automatic stomp_test();
		logic [PREG_W-1:0] dst;
		logic [DATA_W-1:0] v;
		logic [DATA_W-1:0] w;
		v = $random(seed);
		w = $random(seed);
		// Index 5 is wrong-path at dispatch only
		// Index 7 is a live neighbour
		stomp    = '0;
		stomp[5] = 1'b1;
		send_ready(OP_ADD, 4'd5, 1'b0, dst);
		// Cleared before the issue edge so only the dispatch stomp can cancel it
		stomp[5] = 1'b0;
		send_ready(OP_OR, 4'd7, 1'b1, dst);
		// Two waiters on bypass tag 43
		// Index 6 gets cancelled while waiting
		dst = next_tag;
		next_tag++;
		set_lane(0, FU_ALU, OP_ADD, dst, 4'd6, 6'd43, 1'b0, '0, '0, 1'b1, w);
		absent_tags.push_back(dst);
		tick();
		dst = next_tag;
		next_tag++;
		set_lane(0, FU_ALU, OP_AND, dst, 4'd8, 6'd43, 1'b0, '0, '0, 1'b1, w);
		expect_result(dst, reference_alu(OP_AND, v, w));
		tick();
		clear_lanes();
		stomp[6] = 1'b1;
		tick();
		drive_bypass(6'd43, v);
		drain();
		stomp = '0;
		end_test("stomp");
	endtask

	task automatic full_stall_test();
		logic [PREG_W-1:0] dst;
		int                start_checked;
		int                idx;
		start_checked = checked_count;
		stall = 1'b1;
		for (int i = 0; i < NRSE; i++) begin
			idx = {$random(seed)} % 7;
			send_ready(alu_ops[idx], '0, 1'b1, dst);
		end
		assert (busy) else begin
			$display("Station not busy after %0d stalled dispatches at time %0t", NRSE, $time);
			error_count++;
		end
		expect_quiet(3);
		stall = 1'b0;
		drain();
		assert (checked_count - start_checked == NRSE) else begin
			$display("Only %0d of %0d held instructions completed", checked_count - start_checked,
				NRSE);
			error_count++;
		end
		end_test("full_and_stall");
	endtask

	// Non-ALU work sits on the higher lane
	// which would win the select if its unit were ignored
	task automatic lane_test();
		logic [PREG_W-1:0] d0;
		logic [PREG_W-1:0] d1;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		for (int round = 0; round < 2; round++) begin
			a = $random(seed);
			b = $random(seed);
			d0 = next_tag;
			next_tag++;
			d1 = next_tag;
			next_tag++;
			if (round == 0) begin
				set_lane(0, FU_ALU, OP_SUB, d0, '0, '0, 1'b1, a, '0, 1'b1, b);
				set_lane(1, FU_FPU, OP_ADD, d1, '0, '0, 1'b1, a, '0, 1'b1, b);
				expect_result(d0, reference_alu(OP_SUB, a, b));
			end else begin
				set_lane(0, FU_ALU, OP_XOR, d0, '0, '0, 1'b1, a, '0, 1'b1, b);
				set_lane(1, FU_MEM, OP_ADD, d1, '0, '0, 1'b1, a, '0, 1'b1, b);
				expect_result(d0, reference_alu(OP_XOR, a, b));
			end
			absent_tags.push_back(d1);
			tick();
			clear_lanes();
		end
		drain();
		end_test("lane_filter");
	endtask

	// ========================================================================
	// Main sequence and watchdog
	// ========================================================================

	initial begin
		lane_valid       = '0;
		lane_dst         = '0;
		lane_rob         = '0;
		lane_src_tag     = '0;
		lane_src_present = '0;
		lane_src_value   = '0;
		for (int i = 0; i < NLANE; i++) begin
			lane_unit[i] = FU_ALU;
			lane_op[i]   = OP_NOP;
		end
		available = 1'b1;
		stall     = 1'b0;
		stomp     = '0;
		byp_valid = 1'b0;
		byp_tag   = '0;
		byp_value = '0;
		clear_model();
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		tick();
		assert (!busy && !result_valid) else begin
			$display("Station not idle after reset at time %0t", $time);
			error_count++;
		end
		opcode_test();
		bypass_test();
		chain_test();
		stomp_test();
		full_stall_test();
		lane_test();
		$display("Tests %0d, results checked %0d, errors %0d", test_count, checked_count,
			error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Twenty cycles per instruction sent covers every drain
	initial begin
		#((RESET_CYCLES + TOTAL_LEN * 20) * CLK_PERIOD);
		$display("Timeout, the run hung and did not finish within %0d cycles",
			RESET_CYCLES + TOTAL_LEN * 20);
		$display("TEST FAIL");
		$finish;
	end

endmodule
